// File: mc_pkg.sv
/* shared sizes, operation codes and packet layouts for the manycore row
   imported by every block that builds or reads a request or a response */

package mc_pkg;

  // ----------------------------------------
  // row geometry
  // ----------------------------------------

  // tiles in the row addressed by x coordinate
  localparam int NUM_TILES = 4;
  localparam int X_W       = 2;

  // word memory inside each tile
  localparam int ADDR_W    = 4;
  localparam int MEM_WORDS = 1 << ADDR_W;
  localparam int DATA_W    = 32;

  // tag is echoed back so the host can match responses
  localparam int TAG_W     = 4;

  // ----------------------------------------
  // endpoint queue sizing
  // ----------------------------------------

  // incoming request queue
  localparam int FWD_FIFO_ELS = 2;
  // outgoing response queue and the starting credit count
  localparam int REV_FIFO_ELS = 2;
  // counter must be able to hold the full credit count
  localparam int CREDIT_W     = $clog2(REV_FIFO_ELS + 1);

  // ----------------------------------------
  // packet formats
  // ----------------------------------------

  typedef enum logic [0:0] {
    e_mc_load  = 1'b0,
    e_mc_store = 1'b1
  } mc_op_e;

  // request from the host toward a tile
  typedef struct packed {
    mc_op_e              op;
    logic [X_W-1:0]      x_cord;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [TAG_W-1:0]    tag;
  } mc_packet_s;

  // response from a tile back to the host
  // x_cord names the tile that answered
  // data is the loaded word or zero for a store
  typedef struct packed {
    mc_op_e              op;
    logic [X_W-1:0]      x_cord;
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   data;
  } mc_return_packet_s;

endpackage

// File: mc_fifo.sv
/* small synchronous queue, element type set by parameter
   holds requests on the way in and responses on the way out of a tile */

`timescale 1ns/10ps

module mc_fifo #(
  parameter int  els_p  = 2,
  parameter type elem_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,

  // enqueue side with valid and ready
  input  logic  v_i,
  input  elem_t data_i,
  output logic  ready_o,

  // dequeue side with valid and yumi
  output logic  v_o,
  output elem_t data_o,
  input  logic  yumi_i
);

  localparam int ptr_w = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w = $clog2(els_p + 1);

  // circular storage with its pointers and occupancy
  elem_t             mem_r [els_p];
  logic [ptr_w-1:0]  wr_ptr_r;
  logic [ptr_w-1:0]  rd_ptr_r;
  logic [cnt_w-1:0]  count_r;

  logic enq;
  logic deq;

  // ready only looks at occupancy and never at yumi_i
  assign ready_o = (count_r != cnt_w'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // pointers wrap at els_p, so depth need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // occupancy only moves when exactly one side fires
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// File: mc_endpoint_fc.sv
/* tile endpoint with queues for requests from the row and responses back to it
   requests reach the client only when a response slot is reserved */

`timescale 1ns/10ps

module mc_endpoint_fc (
  input  logic                      clk_i,
  input  logic                      reset_i,

  // from the request router
  input  logic                      net_v_i,
  input  mc_pkg::mc_packet_s        net_packet_i,
  output logic                      net_ready_o,

  // request toward the memory client
  output mc_pkg::mc_packet_s        packet_o,
  output logic                      packet_v_o,
  input  logic                      packet_yumi_i,

  // response from the memory client, no ready
  input  mc_pkg::mc_return_packet_s return_packet_i,
  input  logic                      return_packet_v_i,

  // response toward the arbiter
  output mc_pkg::mc_return_packet_s return_packet_o,
  output logic                      return_packet_v_o,
  input  logic                      return_packet_yumi_i
);

  import mc_pkg::*;

  // forward fifo head before credit gating
  logic                fwd_v_lo;
  // handshakes that move credits
  logic                fwd_deq;
  logic                rev_deq;

  logic [CREDIT_W-1:0] credit_r;
  logic [CREDIT_W-1:0] credit_avail;
  logic                credit_has_space;

  // ----------------------------------------
  // forward path for requests
  // ----------------------------------------

  // net_ready_o is simply "forward fifo not full"
  mc_fifo #(
    .els_p  (FWD_FIFO_ELS),
    .elem_t (mc_packet_s)
  ) fwd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (net_v_i),
    .data_i  (net_packet_i),
    .ready_o (net_ready_o),
    .v_o     (fwd_v_lo),
    .data_o  (packet_o),
    .yumi_i  (packet_yumi_i)
  );

  // client only sees a request when its response has a slot waiting
  assign packet_v_o = fwd_v_lo & credit_has_space;
  assign fwd_deq    = packet_v_o & packet_yumi_i;

  // ----------------------------------------
  // reverse fifo credits
  // ----------------------------------------

  // one credit per free reverse fifo entry, minus requests in flight
  // in the client. a dequeue this cycle frees its credit right away
  assign rev_deq          = return_packet_v_o & return_packet_yumi_i;
  assign credit_avail     = credit_r + CREDIT_W'(rev_deq);
  assign credit_has_space = (credit_avail != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= CREDIT_W'(REV_FIFO_ELS);
    end else begin
      // take a credit for every request the client accepts
      credit_r <= credit_avail - CREDIT_W'(fwd_deq);
    end
  end

  // ----------------------------------------
  // reverse path for responses
  // ----------------------------------------

  // credits guarantee room, so the ready here is never needed
  mc_fifo #(
    .els_p  (REV_FIFO_ELS),
    .elem_t (mc_return_packet_s)
  ) rev_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (return_packet_v_i),
    .data_i  (return_packet_i),
    .ready_o (),
    .v_o     (return_packet_v_o),
    .data_o  (return_packet_o),
    .yumi_i  (return_packet_yumi_i)
  );

endmodule

// File: mc_tile_mem.sv
/* per-tile word memory client behind the endpoint
   takes one request per cycle and answers with a registered response */

`timescale 1ns/10ps

module mc_tile_mem (
  input  logic                      clk_i,
  input  logic                      reset_i,

  // tile identity tied off by the row
  input  logic [mc_pkg::X_W-1:0]    tile_x_i,

  // request from the endpoint
  input  mc_pkg::mc_packet_s        packet_i,
  input  logic                      packet_v_i,
  output logic                      packet_yumi_o,

  // one-cycle response back to the endpoint
  output mc_pkg::mc_return_packet_s return_packet_o,
  output logic                      return_packet_v_o
);

  import mc_pkg::*;

  logic [DATA_W-1:0] mem_r [MEM_WORDS];
  mc_return_packet_s ret_r;
  logic              ret_v_r;
  logic              is_store;

  // never stalls, so take whatever is offered
  assign packet_yumi_o = packet_v_i;
  assign is_store      = (packet_i.op == e_mc_store);

  // word array and response valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_r[w] <= '0;
      end
      ret_v_r <= 1'b0;
    end else begin
      if (packet_yumi_o && is_store) begin
        mem_r[packet_i.addr] <= packet_i.data;
      end
      ret_v_r <= packet_yumi_o;
    end
  end

  // response payload reads the old word
  always_ff @(posedge clk_i) begin
    if (packet_yumi_o) begin
      ret_r.op     <= packet_i.op;
      ret_r.x_cord <= tile_x_i;
      ret_r.tag    <= packet_i.tag;
      // stores answer with zero data
      ret_r.data   <= is_store ? '0 : mem_r[packet_i.addr];
    end
  end

  assign return_packet_o   = ret_r;
  assign return_packet_v_o = ret_v_r;

endmodule

// File: mc_req_router.sv
/* steers host requests to one tile of the row by x coordinate
   the host only sees ready from the tile it is addressing */

`timescale 1ns/10ps

module mc_req_router (
  // host side
  input  logic                          req_v_i,
  input  mc_pkg::mc_packet_s            req_packet_i,
  output logic                          req_ready_o,

  // tile side with one valid per tile and a shared packet
  output logic [mc_pkg::NUM_TILES-1:0]  tile_v_o,
  output mc_pkg::mc_packet_s            tile_packet_o,
  input  logic [mc_pkg::NUM_TILES-1:0]  tile_ready_i
);

  import mc_pkg::*;

  logic [NUM_TILES-1:0] tile_sel;

  // ----------------------------------------
  // x coordinate decode
  // ----------------------------------------

  // one-hot select from the destination x
  always_comb begin
    for (int i = 0; i < NUM_TILES; i++) begin
      tile_sel[i] = (req_packet_i.x_cord == X_W'(i));
    end
  end

  // every tile sees the same packet and only the valid is steered
  assign tile_packet_o = req_packet_i;
  assign tile_v_o      = tile_sel & {NUM_TILES{req_v_i}};

  // ----------------------------------------
  // back-pressure
  // ----------------------------------------

  // ready comes from the addressed endpoint only,
  // so a full tile does not block traffic to the others
  assign req_ready_o = tile_ready_i[req_packet_i.x_cord];

endmodule

// File: mc_resp_arbiter.sv
/* round-robin merge of the tiles' response queue heads onto the host port
   a tile is popped only when the host takes its response */

`timescale 1ns/10ps

module mc_resp_arbiter (
  input  logic                                              clk_i,
  input  logic                                              reset_i,

  // one reverse fifo head per tile
  input  logic [mc_pkg::NUM_TILES-1:0]                      tile_v_i,
  input  mc_pkg::mc_return_packet_s [mc_pkg::NUM_TILES-1:0] tile_packet_i,
  output logic [mc_pkg::NUM_TILES-1:0]                      tile_yumi_o,

  // host response port with valid and ready
  output logic                                              resp_v_o,
  output mc_pkg::mc_return_packet_s                         resp_packet_o,
  input  logic                                              resp_ready_i
);

  import mc_pkg::*;

  // last tile that completed a transfer
  logic [X_W-1:0] last_r;
  logic [X_W-1:0] grant_idx;
  logic           grant_found;
  logic           xfer;

  // search starts one past the last grant and wraps around the row
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int off = 1; off <= NUM_TILES; off++) begin
      cand = (int'(last_r) + off) % NUM_TILES;
      if (!grant_found && tile_v_i[cand]) begin
        grant_found = 1'b1;
        grant_idx   = X_W'(cand);
      end
    end
  end

  assign resp_v_o      = grant_found;
  assign resp_packet_o = tile_packet_i[grant_idx];
  assign xfer          = resp_v_o & resp_ready_i;

  // pop the granted head only on a completed transfer
  always_comb begin
    tile_yumi_o = '0;
    tile_yumi_o[grant_idx] = xfer;
  end

  // ----------------------------------------
  // rotation pointer
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // start on the last tile so tile 0 goes first
      last_r <= X_W'(NUM_TILES - 1);
    end else if (xfer) begin
      last_r <= grant_idx;
    end
  end

endmodule

// File: mc_row_top.sv
/* one row of tiles with a router in, an endpoint and memory per tile and an arbiter out
   the host injects requests by x coordinate and drains tagged responses */

`timescale 1ns/10ps

module mc_row_top (
  input  logic                      clk_i,
  input  logic                      reset_i,

  // host request port
  input  logic                      req_v_i,
  input  mc_pkg::mc_packet_s        req_packet_i,
  output logic                      req_ready_o,

  // host response port
  output logic                      resp_v_o,
  output mc_pkg::mc_return_packet_s resp_packet_o,
  input  logic                      resp_ready_i
);

  import mc_pkg::*;

  // router to endpoints
  logic [NUM_TILES-1:0]                  net_v;
  mc_packet_s                            net_packet;
  logic [NUM_TILES-1:0]                  net_ready;

  // endpoints to arbiter
  logic [NUM_TILES-1:0]                  ep_ret_v;
  mc_return_packet_s [NUM_TILES-1:0]     ep_ret_packet;
  logic [NUM_TILES-1:0]                  ep_ret_yumi;

  mc_req_router router (
    .req_v_i       (req_v_i),
    .req_packet_i  (req_packet_i),
    .req_ready_o   (req_ready_o),
    .tile_v_o      (net_v),
    .tile_packet_o (net_packet),
    .tile_ready_i  (net_ready)
  );

  // ----------------------------------------
  // tiles
  // ----------------------------------------

  for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
    // endpoint to memory client
    mc_packet_s        mem_packet;
    logic              mem_v;
    logic              mem_yumi;
    mc_return_packet_s mem_ret_packet;
    logic              mem_ret_v;

    mc_endpoint_fc endpoint (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .net_v_i              (net_v[i]),
      .net_packet_i         (net_packet),
      .net_ready_o          (net_ready[i]),
      .packet_o             (mem_packet),
      .packet_v_o           (mem_v),
      .packet_yumi_i        (mem_yumi),
      .return_packet_i      (mem_ret_packet),
      .return_packet_v_i    (mem_ret_v),
      .return_packet_o      (ep_ret_packet[i]),
      .return_packet_v_o    (ep_ret_v[i]),
      .return_packet_yumi_i (ep_ret_yumi[i])
    );

    // tile x is its position in the row
    mc_tile_mem mem (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .tile_x_i          (X_W'(i)),
      .packet_i          (mem_packet),
      .packet_v_i        (mem_v),
      .packet_yumi_o     (mem_yumi),
      .return_packet_o   (mem_ret_packet),
      .return_packet_v_o (mem_ret_v)
    );
  end

  mc_resp_arbiter arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .tile_v_i      (ep_ret_v),
    .tile_packet_i (ep_ret_packet),
    .tile_yumi_o   (ep_ret_yumi),
    .resp_v_o      (resp_v_o),
    .resp_packet_o (resp_packet_o),
    .resp_ready_i  (resp_ready_i)
  );

endmodule

// File: tb_mc_row.sv
/* directed testbench for the manycore row that checks every response against a word model
   compiled from src.f with tb_mc_row on top and reports one line per test */

`timescale 1ns/10ps

module tb_mc_row;

  import mc_pkg::*;

  // ----------------------------------------
  // run lengths in clock cycles
  // ----------------------------------------

  localparam int N_STREAM = 200;
  // per-test budgets summed into the watchdog
  localparam int CYC_RESET = 20;
  localparam int CYC_T1 = 100;
  localparam int CYC_T2 = 800;
  localparam int CYC_T3 = 60;
  localparam int CYC_T4 = 200;
  localparam int CYC_T5 = 300;
  localparam int CYC_T6 = N_STREAM * 12;
  localparam int WATCHDOG_CYCLES = CYC_RESET + CYC_T1 + CYC_T2 + CYC_T3 + CYC_T4
                                   + CYC_T5 + CYC_T6;

  logic              clk_i;
  logic              reset_i;
  logic              req_v_i;
  mc_packet_s        req_packet_i;
  logic              req_ready_o;
  logic              resp_v_o;
  mc_return_packet_s resp_packet_o;
  logic              resp_ready_i;

  // reference word memory per tile
  logic [DATA_W-1:0] model_mem [NUM_TILES][MEM_WORDS];
  // expected response per tile and tag and whether it is still owed
  mc_return_packet_s expected [NUM_TILES][1 << TAG_W];
  logic              pending [NUM_TILES][1 << TAG_W];
  logic [TAG_W-1:0]  next_tag [NUM_TILES];
  mc_return_packet_s last_exp [NUM_TILES];
  int                exp_order [NUM_TILES];
  mc_return_packet_s rx_q [$];

  integer      seed = 74984;
  int          sent;
  int          received;
  int          errors;
  int          checks;
  int          tests_run;
  int          err_start;
  logic        ready_random;
  logic [63:0] ready_pat;

  mc_row_top DUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (req_v_i),
    .req_packet_i  (req_packet_i),
    .req_ready_o   (req_ready_o),
    .resp_v_o      (resp_v_o),
    .resp_packet_o (resp_packet_o),
    .resp_ready_i  (resp_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic check_resp(input string name, input mc_return_packet_s got,
                            input mc_return_packet_s exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------
  // host side helpers
  // ----------------------------------------

  // holds reset for five cycles and clears the word model to match
  task automatic apply_reset();
    reset_i = 1'b1;
    for (int x = 0; x < NUM_TILES; x++) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        model_mem[x][a] = '0;
      end
    end
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
  endtask

  // builds the owed response from the model and books it
  function automatic void book_request(input mc_packet_s pkt);
    mc_return_packet_s exp;
    exp.op     = pkt.op;
    exp.x_cord = pkt.x_cord;
    exp.tag    = pkt.tag;
    if (pkt.op == e_mc_store) begin
      model_mem[pkt.x_cord][pkt.addr] = pkt.data;
      exp.data = '0;
    end else begin
      exp.data = model_mem[pkt.x_cord][pkt.addr];
    end
    if (pending[pkt.x_cord][pkt.tag]) begin
      $display("time %0t: tag %0d of tile %0d reused while still owed", $time, pkt.tag,
               pkt.x_cord);
      errors++;
    end
    expected[pkt.x_cord][pkt.tag] = exp;
    pending[pkt.x_cord][pkt.tag]  = 1'b1;
    last_exp[pkt.x_cord]          = exp;
    next_tag[pkt.x_cord]          = next_tag[pkt.x_cord] + 1'b1;
    sent++;
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic send_req(input mc_op_e op, input int x, input int addr,
                          input logic [DATA_W-1:0] data, input int max_wait,
                          output logic accepted);
    mc_packet_s pkt;
    int         waited;
    pkt.op       = op;
    pkt.x_cord   = X_W'(x);
    pkt.addr     = ADDR_W'(addr);
    pkt.data     = data;
    pkt.tag      = next_tag[x];
    accepted     = 1'b0;
    waited       = 0;
    req_packet_i = pkt;
    req_v_i      = 1'b1;
    while (!accepted && waited < max_wait) begin
      // ready is settled by mid cycle and the transfer is the next edge
      @(negedge clk_i);
      if (req_ready_o) begin
        accepted = 1'b1;
        book_request(pkt);
      end
      @(posedge clk_i);
      #1;
      waited++;
    end
    req_v_i = 1'b0;
  endtask

  task automatic send_or_flag(input mc_op_e op, input int x, input int addr,
                              input logic [DATA_W-1:0] data, input int max_wait);
    logic acc;
    send_req(op, x, addr, data, max_wait, acc);
    if (!acc) begin
      $display("time %0t: request to tile %0d not accepted in %0d cycles", $time, x, max_wait);
      errors++;
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (sent != received && n < max_cycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (sent != received) begin
      $display("time %0t: %0d responses still missing after %0d cycles", $time,
               sent - received, max_cycles);
      errors++;
    end
  endtask

  // waits until exactly the tiles in mask hold a queued response
  task automatic wait_queued(input logic [NUM_TILES-1:0] mask, input int max_cycles);
    int n;
    n = 0;
    while (DUT.ep_ret_v !== mask && n < max_cycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (DUT.ep_ret_v !== mask) begin
      $display("time %0t: response queues never reached pattern %b", $time, mask);
      errors++;
    end
  endtask

  task automatic check_order(input int count);
    if (rx_q.size() != count) begin
      $display("time %0t: got %0d responses in the round, expected %0d", $time,
               rx_q.size(), count);
      errors++;
    end else begin
      for (int i = 0; i < count; i++) begin
        check_resp("resp_packet_o", rx_q[i], last_exp[exp_order[i]]);
      end
    end
  endtask

  task automatic start_test();
    err_start = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    $display("test %-14s done, %0d errors", name, errors - err_start);
  endtask

  // ----------------------------------------
  // response side sampled mid cycle
  // ----------------------------------------

  initial begin : resp_monitor
    mc_return_packet_s got;
    forever begin
      @(negedge clk_i);
      if (!reset_i && resp_v_o && resp_ready_i) begin
        got = resp_packet_o;
        rx_q.push_back(got);
        if (!pending[got.x_cord][got.tag]) begin
          $display("time %0t: response from tile %0d tag %0d was not owed", $time,
                   got.x_cord, got.tag);
          errors++;
        end else begin
          check_resp("resp_packet_o", got, expected[got.x_cord][got.tag]);
          pending[got.x_cord][got.tag] = 1'b0;
        end
        received++;
      end
    end
  end

  // random response ready while streaming
  initial begin : ready_driver
    int cyc;
    cyc = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ready_random) begin
        resp_ready_i = ready_pat[cyc % 64];
      end
      cyc++;
    end
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset();
    start_test();
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("resp_v_o", resp_v_o, 1'b0);
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b1;
    // memories clear on reset, so every load gives zero
    for (int x = 0; x < NUM_TILES; x++) begin
      send_or_flag(e_mc_load, x, $unsigned($random(seed)) % MEM_WORDS, '0, 10);
    end
    wait_drain(40);
    end_test("reset");
  endtask

  task automatic test_store_load();
    start_test();
    for (int x = 0; x < NUM_TILES; x++) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        send_or_flag(e_mc_store, x, a, $random(seed), 10);
      end
    end
    for (int x = 0; x < NUM_TILES; x++) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        send_or_flag(e_mc_load, x, a, '0, 10);
      end
    end
    wait_drain(60);
    end_test("store_load");
  endtask

  task automatic test_latency();
    start_test();
    send_or_flag(e_mc_load, 2, 5, '0, 10);
    // response must show in the third cycle after the accepting edge
    for (int k = 1; k <= 3; k++) begin
      @(negedge clk_i);
      check_bit("resp_v_o", resp_v_o, (k == 3));
    end
    @(posedge clk_i);
    #1;
    wait_drain(10);
    end_test("latency");
  endtask

  task automatic test_backpressure();
    int   n_acc;
    logic acc;
    start_test();
    resp_ready_i = 1'b0;
    n_acc = 0;
    // two fit in the reverse queue and two in the forward queue
    for (int i = 0; i < 8; i++) begin
      send_req(e_mc_load, 1, i, '0, 4, acc);
      if (!acc) begin
        break;
      end
      n_acc++;
    end
    if (n_acc != REV_FIFO_ELS + FWD_FIFO_ELS) begin
      $display("time %0t: stalled tile 1 took %0d requests, expected %0d", $time, n_acc,
               REV_FIFO_ELS + FWD_FIFO_ELS);
      errors++;
    end
    // a full tile must not block its neighbour
    send_or_flag(e_mc_store, 2, 3, $random(seed), 4);
    req_packet_i.x_cord = X_W'(1);
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b0);
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b1;
    wait_drain(60);
    end_test("backpressure");
  endtask

  task automatic test_round_robin();
    start_test();
    resp_ready_i = 1'b0;
    // reset puts the pointer on the last tile so tile 0 leads
    apply_reset();
    for (int x = 0; x < NUM_TILES; x++) begin
      send_or_flag(e_mc_load, x, x, '0, 10);
    end
    wait_queued(4'b1111, 20);
    rx_q.delete();
    resp_ready_i = 1'b1;
    wait_drain(20);
    for (int i = 0; i < NUM_TILES; i++) begin
      exp_order[i] = i;
    end
    check_order(NUM_TILES);
    // one transfer from tile 1 leaves the pointer there
    send_or_flag(e_mc_load, 1, 0, '0, 10);
    wait_drain(20);
    resp_ready_i = 1'b0;
    send_or_flag(e_mc_load, 0, 1, '0, 10);
    send_or_flag(e_mc_load, 2, 1, '0, 10);
    send_or_flag(e_mc_load, 3, 1, '0, 10);
    wait_queued(4'b1101, 20);
    rx_q.delete();
    resp_ready_i = 1'b1;
    wait_drain(20);
    // search resumes after tile 1 and wraps
    exp_order[0] = 2;
    exp_order[1] = 3;
    exp_order[2] = 0;
    check_order(3);
    end_test("round_robin");
  endtask

  task automatic test_stream();
    mc_op_e op;
    start_test();
    // every eighth cycle ready is forced so the stream keeps moving
    ready_pat    = {$random(seed), $random(seed)} | 64'h0101_0101_0101_0101;
    ready_random = 1'b1;
    for (int i = 0; i < N_STREAM; i++) begin
      op = ($random(seed) & 1) ? e_mc_store : e_mc_load;
      send_or_flag(op, $unsigned($random(seed)) % NUM_TILES,
                   $unsigned($random(seed)) % MEM_WORDS, $random(seed), 100);
    end
    ready_random = 1'b0;
    resp_ready_i = 1'b1;
    wait_drain(100);
    end_test("stream");
  endtask

  initial begin : main
    req_v_i      = 1'b0;
    req_packet_i = '0;
    resp_ready_i = 1'b0;
    reset_i      = 1'b1;
    ready_random = 1'b0;
    ready_pat    = '0;
    sent         = 0;
    received     = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    for (int x = 0; x < NUM_TILES; x++) begin
      next_tag[x] = '0;
      for (int t = 0; t < (1 << TAG_W); t++) begin
        pending[x][t] = 1'b0;
      end
    end
    apply_reset();
    test_reset();
    test_store_load();
    test_latency();
    test_backpressure();
    test_round_robin();
    test_stream();
    $display("tests %0d, checks %0d, responses %0d, errors %0d", tests_run, checks,
             received, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
mc_pkg.sv
mc_fifo.sv
mc_endpoint_fc.sv
mc_tile_mem.sv
mc_req_router.sv
mc_resp_arbiter.sv
mc_row_top.sv
tb_mc_row.sv

// File: Makefile
# Verilator build and run of the manycore row testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal -j 0
TOP      := tb_mc_row
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
